/* tb.f */
common/debug_ram_pkg.sv
source/mem_ctrl.sv
source/mcr_store.sv
source/dram_store.sv
vram/vram_store.sv
source/debug_ram_top.sv
dv/debug_ram_properties.sv
dv/debug_ram_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = debug_ram_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/debug_ram_tb.sv */
// testbench with table-driven checks of the microcode, main-memory and video paths

`timescale 1ns/100ps
`default_nettype none

module debug_ram_tb
   import debug_ram_pkg::*;
();

   localparam int TB_DRAM_DEPTH = 1024;
   localparam int NUM_ROWS      = 18;
   localparam int CYCLE_LIMIT   = NUM_ROWS * 16 + 50;
   localparam int FETCH_HOLD    = 3;

   typedef enum int {OP_MCR, OP_DWR, OP_DRD, OP_VWR, OP_VRD, OP_VGA} op_t;

   // main-memory rows with cond 1 are issued right after the previous ack
   // video writes with cond 1 hold fetch high
   // video writes with cond 2 add a microcode write alongside
   typedef struct {
      op_t         op;
      int          addr;
      int          cond;
      bit          rnd;
      logic [63:0] data;
   } row_t;

   logic                   cpu_clk;
   logic                   reset;
   logic                   fetch;
   logic                   prefetch;
   logic [MCR_ADDR_W-1:0]  mcr_addr;
   logic [MCR_WORD_W-1:0]  mcr_data_in;
   logic                   mcr_write;
   logic [MCR_WORD_W-1:0]  mcr_data_out;
   logic                   mcr_done;
   logic [DRAM_ADDR_W-1:0] dram_addr;
   logic [DATA_W-1:0]      dram_data_in;
   logic                   dram_read_req;
   logic                   dram_write_req;
   logic [DATA_W-1:0]      dram_data_out;
   logic                   dram_ready;
   logic                   dram_done;
   logic [VRAM_ADDR_W-1:0] vram_cpu_addr;
   logic [DATA_W-1:0]      vram_cpu_data_in;
   logic                   vram_cpu_write;
   logic                   vram_cpu_req;
   logic [DATA_W-1:0]      vram_cpu_data_out;
   logic                   vram_cpu_ready;
   logic                   vram_cpu_done;
   logic [VRAM_ADDR_W-1:0] vram_vga_addr;
   logic [DATA_W-1:0]      vram_vga_data_out;

   row_t              rows [NUM_ROWS];
   logic [DATA_W-1:0] dram_exp [int];
   logic [DATA_W-1:0] vram_exp [int];
   logic [31:0]       lfsr = 32'd31;
   int                cyc = 0;
   int                last_ack_cyc = 0;
   int                errors = 0;

   debug_ram_top #(.DRAM_DEPTH(TB_DRAM_DEPTH)) dut_i (.*);

   always #20 cpu_clk = ~cpu_clk;

   // run limit
   always @(posedge cpu_clk)
   begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT)
      begin
         $display("timeout: run stopped after %0d cycles", cyc);
         $display("** FAIL **");
         $finish;
      end
   end

   // ------------------------------
   // stimulus table
   // ------------------------------
   task automatic load_table();
      rows[0]  = '{OP_MCR, 5,    0, 1'b0, 64'h0001_2345_6789_abcd};
      rows[1]  = '{OP_MCR, 300,  0, 1'b1, 64'h0};
      rows[2]  = '{OP_DWR, 12,   0, 1'b0, 64'hcafe_0012};
      rows[3]  = '{OP_DRD, 12,   0, 1'b0, 64'h0};
      rows[4]  = '{OP_DWR, 700,  0, 1'b1, 64'h0};
      rows[5]  = '{OP_DRD, 700,  1, 1'b0, 64'h0};
      rows[6]  = '{OP_DWR, 1030, 0, 1'b0, 64'hdead_beef};
      rows[7]  = '{OP_DRD, 1030, 0, 1'b0, 64'h0};
      // 6 shares its low address bits with 1030
      rows[8]  = '{OP_DRD, 6,    0, 1'b0, 64'h0};
      rows[9]  = '{OP_DWR, 13,   0, 1'b1, 64'h0};
      rows[10] = '{OP_DWR, 14,   1, 1'b1, 64'h0};
      rows[11] = '{OP_DRD, 14,   1, 1'b0, 64'h0};
      rows[12] = '{OP_VWR, 100,  0, 1'b1, 64'h0};
      rows[13] = '{OP_VWR, 101,  1, 1'b0, 64'h0bad_f00d};
      rows[14] = '{OP_VWR, 102,  2, 1'b1, 64'h0};
      rows[15] = '{OP_VRD, 101,  0, 1'b0, 64'h0};
      rows[16] = '{OP_VGA, 100,  0, 1'b0, 64'h0};
      rows[17] = '{OP_VGA, 102,  0, 1'b0, 64'h0};
   endtask

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_random(input int nbits, output logic [63:0] val);
      val = '0;
      for (int i = 0; i < nbits; i++)
      begin
         val[i] = lfsr[0];
         lfsr = next_lfsr(lfsr);
      end
   endtask

   function automatic logic [DATA_W-1:0] dram_expect(input int a);
      // unmapped space reads as all ones
      if (a >= TB_DRAM_DEPTH)
         return '1;
      return dram_exp.exists(a) ? dram_exp[a] : '0;
   endfunction

   function automatic logic [DATA_W-1:0] vram_expect(input int a);
      return vram_exp.exists(a) ? vram_exp[a] : '0;
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp_val);
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp_val);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("error at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge cpu_clk);
         dram_read_req  <= 1'b0;
         dram_write_req <= 1'b0;
         vram_cpu_write <= 1'b0;
         vram_cpu_req   <= 1'b0;
         mcr_write      <= 1'b0;
         prefetch       <= 1'b0;
         fetch          <= 1'b0;
      end
   endtask

   // ------------------------------
   // row handlers
   // ------------------------------
   task automatic mcr_row(input row_t r, input logic [63:0] d);
      @(posedge cpu_clk);
      mcr_addr    <= MCR_ADDR_W'(r.addr);
      mcr_data_in <= d[MCR_WORD_W-1:0];
      mcr_write   <= 1'b1;
      @(posedge cpu_clk);
      mcr_write <= 1'b0;
      prefetch  <= 1'b1;
      @(negedge cpu_clk);
      if (mcr_done !== 1'b1)
         report_failure("mcr_done did not follow the microcode write");
      @(posedge cpu_clk);
      prefetch <= 1'b0;
      @(negedge cpu_clk);
      if (mcr_done !== 1'b0)
         report_failure("mcr_done stayed high for more than one cycle");
      if (mcr_data_out !== d[MCR_WORD_W-1:0])
         report_mismatch("mcr_data_out", 64'(mcr_data_out), 64'(d[MCR_WORD_W-1:0]));
   endtask

   task automatic dram_row(input row_t r, input logic [63:0] d);
      int                wait_n;
      logic              is_wr;
      logic [DATA_W-1:0] exp_word;
      is_wr = (r.op == OP_DWR);
      @(posedge cpu_clk);
      dram_addr      <= DRAM_ADDR_W'(r.addr);
      dram_data_in   <= d[DATA_W-1:0];
      dram_write_req <= is_wr;
      dram_read_req  <= !is_wr;
      // request held until its ack
      wait_n = 0;
      @(negedge cpu_clk);
      while (!dram_done && !dram_ready)
      begin
         @(posedge cpu_clk);
         wait_n++;
         @(negedge cpu_clk);
      end
      if (is_wr ? !dram_done : !dram_ready)
         report_failure("main memory answered with the wrong kind of acknowledge");
      if (r.cond == 0 && wait_n != DRAM_ACK_DELAY)
         report_failure($sformatf("main-memory ack after %0d cycles, expected %0d",
                                  wait_n, DRAM_ACK_DELAY));
      if (r.cond != 0 && cyc - last_ack_cyc < DRAM_ACK_DELAY + 1)
         report_failure($sformatf("main-memory ack only %0d cycles after the previous one",
                                  cyc - last_ack_cyc));
      last_ack_cyc = cyc;
      if (is_wr)
      begin
         if (r.addr < TB_DRAM_DEPTH)
            dram_exp[r.addr] = d[DATA_W-1:0];
      end
      else
      begin
         exp_word = dram_expect(r.addr);
         if (dram_data_out !== exp_word)
            report_mismatch("dram_data_out", 64'(dram_data_out), 64'(exp_word));
      end
   endtask

   task automatic vram_write_row(input row_t r, input logic [63:0] d);
      int wait_n;
      int exp_n;
      exp_n = (r.cond == 1) ? FETCH_HOLD + 2 : (r.cond == 2) ? 3 : 2;
      @(posedge cpu_clk);
      vram_cpu_addr    <= VRAM_ADDR_W'(r.addr);
      vram_cpu_data_in <= d[DATA_W-1:0];
      vram_cpu_write   <= 1'b1;
      fetch            <= (r.cond == 1);
      if (r.cond == 2)
      begin
         // spare microcode word that is never read back
         mcr_addr    <= '1;
         mcr_data_in <= '0;
         mcr_write   <= 1'b1;
      end
      @(posedge cpu_clk);
      vram_cpu_write <= 1'b0;
      mcr_write      <= 1'b0;
      wait_n = 1;
      @(negedge cpu_clk);
      while (!vram_cpu_done)
      begin
         @(posedge cpu_clk);
         wait_n++;
         if (wait_n == FETCH_HOLD + 1)
            fetch <= 1'b0;
         @(negedge cpu_clk);
      end
      if (wait_n != exp_n)
         report_failure($sformatf("vram_cpu_done after %0d cycles, expected %0d",
                                  wait_n, exp_n));
      vram_exp[r.addr] = d[DATA_W-1:0];
      if (vram_cpu_data_out !== d[DATA_W-1:0])
         report_mismatch("vram_cpu_data_out", 64'(vram_cpu_data_out), 64'(d[DATA_W-1:0]));
   endtask

   // three back-to-back requests at one address
   task automatic vram_read_row(input row_t r);
      logic exp_rdy;
      @(posedge cpu_clk);
      vram_cpu_addr <= VRAM_ADDR_W'(r.addr);
      vram_cpu_req  <= 1'b1;
      for (int i = 0; i < VRAM_READ_DELAY + 3; i++)
      begin
         @(negedge cpu_clk);
         exp_rdy = (i >= VRAM_READ_DELAY) && (i < VRAM_READ_DELAY + 3);
         if (vram_cpu_ready !== exp_rdy)
            report_mismatch("vram_cpu_ready", 64'(vram_cpu_ready), 64'(exp_rdy));
         if (vram_cpu_ready && vram_cpu_data_out !== vram_expect(r.addr))
            report_mismatch("vram_cpu_data_out", 64'(vram_cpu_data_out),
                            64'(vram_expect(r.addr)));
         @(posedge cpu_clk);
         if (i == 2)
            vram_cpu_req <= 1'b0;
      end
   endtask

   task automatic scanout_row(input row_t r);
      @(posedge cpu_clk);
      vram_vga_addr <= VRAM_ADDR_W'(r.addr);
      @(negedge cpu_clk);
      if (vram_vga_data_out !== vram_expect(r.addr))
         report_mismatch("vram_vga_data_out", 64'(vram_vga_data_out),
                         64'(vram_expect(r.addr)));
   endtask

   task automatic run_row(input row_t r);
      logic [63:0] d;
      if (!(r.cond == 1 && (r.op == OP_DWR || r.op == OP_DRD)))
         idle_cycles(2);
      if (r.rnd)
         draw_random((r.op == OP_MCR) ? MCR_WORD_W : DATA_W, d);
      else
         d = r.data;
      case (r.op)
         OP_MCR:         mcr_row(r, d);
         OP_DWR, OP_DRD: dram_row(r, d);
         OP_VWR:         vram_write_row(r, d);
         OP_VRD:         vram_read_row(r);
         default:        scanout_row(r);
      endcase
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial
   begin
      int errs_before;
      cpu_clk          = 1'b0;
      reset            = 1'b1;
      fetch            = 1'b0;
      prefetch         = 1'b0;
      mcr_addr         = '0;
      mcr_data_in      = '0;
      mcr_write        = 1'b0;
      dram_addr        = '0;
      dram_data_in     = '0;
      dram_read_req    = 1'b0;
      dram_write_req   = 1'b0;
      vram_cpu_addr    = '0;
      vram_cpu_data_in = '0;
      vram_cpu_write   = 1'b0;
      vram_cpu_req     = 1'b0;
      vram_vga_addr    = '0;
      load_table();
      repeat (2) @(posedge cpu_clk);
      reset <= 1'b0;
      @(negedge cpu_clk);
      if ({mcr_done, dram_ready, dram_done, vram_cpu_done, vram_cpu_ready} !== 5'b0)
         report_failure("an acknowledge is not low right after reset");
      if (mcr_data_out !== '0)
         report_mismatch("mcr_data_out", 64'(mcr_data_out), 64'd0);
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         errs_before = errors;
         run_row(rows[i]);
         $display("row %0d %s addr %0d: %s", i, rows[i].op.name(), rows[i].addr,
                  (errors == errs_before) ? "ok" : "failed");
      end
      $display("rows run %0d, errors %0d", NUM_ROWS, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* dv/debug_ram_properties.sv */
// concurrent checks on acknowledge pulses, video commit and the microcode write flag

`timescale 1ns/100ps
`default_nettype none

module debug_ram_properties (
   input wire logic cpu_clk,
   input wire logic reset,
   input wire logic mcr_write,
   input wire logic mcr_done,
   input wire logic dram_ready,
   input wire logic dram_done,
   input wire logic vram_commit,
   input wire logic vram_cpu_done
);

   // main-memory acks are exclusive
   ack_exclusive: assert property (@(posedge cpu_clk) disable iff (reset)
      !(dram_ready && dram_done))
      else $error("dram_ready and dram_done high together");

   ready_pulse: assert property (@(posedge cpu_clk) disable iff (reset)
      dram_ready |=> !dram_ready)
      else $error("dram_ready longer than one cycle");

   done_pulse: assert property (@(posedge cpu_clk) disable iff (reset)
      dram_done |=> !dram_done)
      else $error("dram_done longer than one cycle");

   // commit grant must precede the video done
   commit_before_done: assert property (@(posedge cpu_clk) disable iff (reset)
      $rose(vram_cpu_done) |-> $past(vram_commit))
      else $error("vram_cpu_done rose without a commit grant");

   mcr_done_follows: assert property (@(posedge cpu_clk) disable iff (reset)
      mcr_done == $past(mcr_write))
      else $error("mcr_done does not follow mcr_write");

endmodule

bind debug_ram_top debug_ram_properties props_i (
   .cpu_clk       (cpu_clk),
   .reset         (reset),
   .mcr_write     (mcr_write),
   .mcr_done      (mcr_done),
   .dram_ready    (dram_ready),
   .dram_done     (dram_done),
   .vram_commit   (vram_commit),
   .vram_cpu_done (vram_cpu_done)
);

`default_nettype wire

/* source/debug_ram_top.sv */
// top level: memory controller with microcode, main-memory and video stores

`timescale 1ns/100ps
`default_nettype none

module debug_ram_top
   import debug_ram_pkg::*;
#(
   parameter int MCR_DEPTH  = 16384,
   parameter int DRAM_DEPTH = 131072,
   parameter int VRAM_DEPTH = 21504
)
(
   input  wire logic                   cpu_clk,
   input  wire logic                   reset,
   input  wire logic                   fetch,
   input  wire logic                   prefetch,
   // microcode
   input  wire logic [MCR_ADDR_W-1:0]  mcr_addr,
   input  wire logic [MCR_WORD_W-1:0]  mcr_data_in,
   input  wire logic                   mcr_write,
   output logic      [MCR_WORD_W-1:0]  mcr_data_out,
   output logic                        mcr_done,
   // main memory
   input  wire logic [DRAM_ADDR_W-1:0] dram_addr,
   input  wire logic [DATA_W-1:0]      dram_data_in,
   input  wire logic                   dram_read_req,
   input  wire logic                   dram_write_req,
   output logic      [DATA_W-1:0]      dram_data_out,
   output logic                        dram_ready,
   output logic                        dram_done,
   // video, CPU side
   input  wire logic [VRAM_ADDR_W-1:0] vram_cpu_addr,
   input  wire logic [DATA_W-1:0]      vram_cpu_data_in,
   input  wire logic                   vram_cpu_write,
   input  wire logic                   vram_cpu_req,
   output logic      [DATA_W-1:0]      vram_cpu_data_out,
   output logic                        vram_cpu_ready,
   output logic                        vram_cpu_done,
   // video, scanout side
   input  wire logic [VRAM_ADDR_W-1:0] vram_vga_addr,
   output logic      [DATA_W-1:0]      vram_vga_data_out
);

   logic dram_wr_en;
   logic vram_commit;

   // ------------------------------
   // sequencing
   // ------------------------------
   mem_ctrl mem_ctrl_i (
      .cpu_clk        (cpu_clk),
      .reset          (reset),
      .fetch          (fetch),
      .mcr_write      (mcr_write),
      .dram_read_req  (dram_read_req),
      .dram_write_req (dram_write_req),
      .mcr_done       (mcr_done),
      .dram_wr_en     (dram_wr_en),
      .dram_ready     (dram_ready),
      .dram_done      (dram_done),
      .vram_commit    (vram_commit)
   );

   // ------------------------------
   // stores
   // ------------------------------
   mcr_store #(.MCR_DEPTH(MCR_DEPTH)) mcr_store_i (
      .cpu_clk      (cpu_clk),
      .reset        (reset),
      .mcr_addr     (mcr_addr),
      .mcr_data_in  (mcr_data_in),
      .mcr_write    (mcr_write),
      .prefetch     (prefetch),
      .mcr_data_out (mcr_data_out)
   );

   dram_store #(.DRAM_DEPTH(DRAM_DEPTH)) dram_store_i (
      .cpu_clk       (cpu_clk),
      .dram_addr     (dram_addr),
      .dram_data_in  (dram_data_in),
      .dram_wr_en    (dram_wr_en),
      .dram_data_out (dram_data_out)
   );

   vram_store #(.VRAM_DEPTH(VRAM_DEPTH)) vram_store_i (
      .cpu_clk           (cpu_clk),
      .reset             (reset),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_req      (vram_cpu_req),
      .vram_commit       (vram_commit),
      .vram_vga_addr     (vram_vga_addr),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_cpu_done     (vram_cpu_done),
      .vram_vga_data_out (vram_vga_data_out)
   );

endmodule

`default_nettype wire

/* vram/vram_store.sv */
// video memory: pending CPU write buffer, CPU read ack pipeline, scanout read port

`timescale 1ns/100ps
`default_nettype none

module vram_store
   import debug_ram_pkg::*;
#(
   parameter int VRAM_DEPTH = 21504
)
(
   input  wire logic                   cpu_clk,
   input  wire logic                   reset,
   input  wire logic [VRAM_ADDR_W-1:0] vram_cpu_addr,
   input  wire logic [DATA_W-1:0]      vram_cpu_data_in,
   input  wire logic                   vram_cpu_write,
   input  wire logic                   vram_cpu_req,
   input  wire logic                   vram_commit,
   input  wire logic [VRAM_ADDR_W-1:0] vram_vga_addr,
   output logic      [DATA_W-1:0]      vram_cpu_data_out,
   output logic                        vram_cpu_ready,
   output logic                        vram_cpu_done,
   output logic      [DATA_W-1:0]      vram_vga_data_out
);

   logic [DATA_W-1:0]          vram [0:VRAM_DEPTH-1];

   logic [VRAM_ADDR_W-1:0]     pend_addr;
   logic [DATA_W-1:0]          pend_data;
   logic                       pend_full;
   logic                       commit_now;
   logic [VRAM_READ_DELAY-1:0] rd_pipe;

   initial
   begin
      for (int i = 0; i < VRAM_DEPTH; i++)
         vram[i] = '0;
   end

   // ------------------------------
   // CPU write buffer
   // ------------------------------
   assign commit_now = vram_commit && pend_full;

   // a new write replaces an entry that has not landed yet
   always_ff @(posedge cpu_clk)
   begin
      if (vram_cpu_write)
      begin
         pend_addr <= vram_cpu_addr;
         pend_data <= vram_cpu_data_in;
      end
   end

   always_ff @(posedge cpu_clk)
   begin
      if (reset)
      begin
         pend_full     <= 1'b0;
         vram_cpu_done <= 1'b0;
      end
      else
      begin
         vram_cpu_done <= commit_now;
         if (vram_cpu_write)
            pend_full <= 1'b1;
         else if (commit_now)
            pend_full <= 1'b0;
      end
   end

   always_ff @(posedge cpu_clk)
   begin
      if (commit_now)
         vram[pend_addr] <= pend_data;
   end

   // ------------------------------
   // read side
   // ------------------------------

   // fixed latency ack, up to three reads in flight
   always_ff @(posedge cpu_clk)
   begin
      if (reset)
         rd_pipe <= '0;
      else
         rd_pipe <= {rd_pipe[VRAM_READ_DELAY-2:0], vram_cpu_req};
   end

   assign vram_cpu_ready    = rd_pipe[VRAM_READ_DELAY-1];
   assign vram_cpu_data_out = vram[vram_cpu_addr];

   // scanout port is always valid
   assign vram_vga_data_out = vram[vram_vga_addr];

endmodule

`default_nettype wire

/* source/dram_store.sv */
// main-memory model: word array with range check on reads and writes

`timescale 1ns/100ps
`default_nettype none

module dram_store
   import debug_ram_pkg::*;
#(
   parameter int DRAM_DEPTH = 131072
)
(
   input  wire logic                   cpu_clk,
   input  wire logic [DRAM_ADDR_W-1:0] dram_addr,
   input  wire logic [DATA_W-1:0]      dram_data_in,
   input  wire logic                   dram_wr_en,
   output logic      [DATA_W-1:0]      dram_data_out
);

   localparam int IDX_W = $clog2(DRAM_DEPTH);

   logic [DATA_W-1:0] dram [0:DRAM_DEPTH-1];
   logic [IDX_W-1:0]  dram_idx;
   logic              in_range;

   initial
   begin
      for (int i = 0; i < DRAM_DEPTH; i++)
         dram[i] = '0;
   end

   // extra top bit keeps the compare valid for any depth
   assign dram_idx = dram_addr[IDX_W-1:0];
   assign in_range = {1'b0, dram_addr} < (DRAM_ADDR_W+1)'(DRAM_DEPTH);

   // writes beyond the array are dropped
   always_ff @(posedge cpu_clk)
   begin
      if (dram_wr_en && in_range)
         dram[dram_idx] <= dram_data_in;
   end

   // unmapped space reads as all ones
   assign dram_data_out = in_range ? dram[dram_idx] : '1;

endmodule

`default_nettype wire

/* source/mcr_store.sv */
// microcode store: word array, write port and prefetch output register

`timescale 1ns/100ps
`default_nettype none

module mcr_store
   import debug_ram_pkg::*;
#(
   parameter int MCR_DEPTH = 16384
)
(
   input  wire logic                  cpu_clk,
   input  wire logic                  reset,
   input  wire logic [MCR_ADDR_W-1:0] mcr_addr,
   input  wire logic [MCR_WORD_W-1:0] mcr_data_in,
   input  wire logic                  mcr_write,
   input  wire logic                  prefetch,
   output logic      [MCR_WORD_W-1:0] mcr_data_out
);

   logic [MCR_WORD_W-1:0] mcr_ram [0:MCR_DEPTH-1];

   // zero contents at time zero
   initial
   begin
      for (int i = 0; i < MCR_DEPTH; i++)
         mcr_ram[i] = '0;
   end

   // write on every edge with mcr_write, no handshake
   always_ff @(posedge cpu_clk)
   begin
      if (mcr_write)
         mcr_ram[mcr_addr] <= mcr_data_in;
   end

   // prefetch register, old word on same-edge write
   always_ff @(posedge cpu_clk)
   begin
      if (reset)
         mcr_data_out <= '0;
      else if (prefetch)
         mcr_data_out <= mcr_ram[mcr_addr];
   end

endmodule

`default_nettype wire

/* source/mem_ctrl.sv */
// memory controller: main-memory acknowledge timing, microcode write flag, video commit grant

`timescale 1ns/100ps
`default_nettype none

module mem_ctrl
   import debug_ram_pkg::*;
(
   input  wire logic cpu_clk,
   input  wire logic reset,
   input  wire logic fetch,
   input  wire logic mcr_write,
   input  wire logic dram_read_req,
   input  wire logic dram_write_req,
   output logic      mcr_done,
   output logic      dram_wr_en,
   output logic      dram_ready,
   output logic      dram_done,
   output logic      vram_commit
);

   // one stage past the ack tap so the pipe drains before the next accept
   logic [DRAM_ACK_DELAY:0] ack_pipe;
   logic                    pipe_idle;
   logic                    accept;
   logic                    ack_tap;
   logic                    was_write;

   // ------------------------------
   // microcode write tracking
   // ------------------------------
   always_ff @(posedge cpu_clk)
   begin
      if (reset)
         mcr_done <= 1'b0;
      else
         mcr_done <= mcr_write;
   end

   // video writes land only outside fetch and microcode write cycles
   assign vram_commit = !fetch && !mcr_done;

   // ------------------------------
   // main-memory acknowledge pipe
   // ------------------------------
   assign pipe_idle  = (ack_pipe == '0);
   assign accept     = pipe_idle && (dram_read_req || dram_write_req);
   assign dram_wr_en = pipe_idle && dram_write_req;

   always_ff @(posedge cpu_clk)
   begin
      if (reset)
      begin
         ack_pipe  <= '0;
         was_write <= 1'b0;
      end
      else
      begin
         ack_pipe <= {ack_pipe[DRAM_ACK_DELAY-1:0], accept};
         // remember the kind of operation for the ack
         if (accept)
            was_write <= dram_write_req;
      end
   end

   assign ack_tap    = ack_pipe[DRAM_ACK_DELAY-1];
   assign dram_done  = ack_tap && was_write;
   assign dram_ready = ack_tap && !was_write;

endmodule

`default_nettype wire

/* common/debug_ram_pkg.sv */
// shared widths and fixed delays for the debug memory model

`default_nettype none

package debug_ram_pkg;

   // ------------------------------
   // microcode store
   // ------------------------------
   localparam int MCR_WORD_W = 49;
   localparam int MCR_ADDR_W = 14;

   // ------------------------------
   // main memory and video
   // ------------------------------
   localparam int DATA_W = 32;

   // processor view, wider than the modelled array
   localparam int DRAM_ADDR_W = 22;
   localparam int VRAM_ADDR_W = 15;

   // ------------------------------
   // handshake timing
   // ------------------------------

   // accepting edge to dram_ready / dram_done
   localparam int DRAM_ACK_DELAY = 5;

   // vram_cpu_req to vram_cpu_ready
   localparam int VRAM_READ_DELAY = 3;

endpackage

`default_nettype wire
